// File: compile.f
+incdir+include
src/rtPkg.sv
src/pixelScanner.sv
src/rayDirection.sv
src/threadGenerator.sv
sim/threadGenerator_chk.sv
sim/threadGeneratorMonitor.sv
sim/threadGenerator_tb.sv

// File: sim/threadGenerator_tb.sv
`include "rtMacros_macros.svh"

module threadGenerator_tb
    import rtPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int FRAME_PIXELS = `FRAMEBUFFER_WIDTH * `FRAMEBUFFER_HEIGHT;
    // Two frames, two cycles a pixel, wide margin for stalls
    localparam int WATCHDOG_CYCLES = 4 * 2 * (2 * FRAME_PIXELS) + 200;

    logic                      clk;
    logic                      resetn;
    logic                      restart;
    logic                      strobe;
    coordT                     x0, y0, viewportHeight;
    logic [`RAY_CORE_SIZE-1:0] fifoFull;
    fixedT                     camPosX, camPosY, camPosZ;
    fixedT                     camBlcX, camBlcY, camBlcZ;
    fixedT                     camRhX, camRhY, camRhZ;
    fixedT                     camRvX, camRvY, camRvZ;
    fixedT                     camCub, camCvb;
    logic                      threadValid;
    coreIdxT                   threadCore;
    coordT                     threadX, threadY;
    fixedT                     rayDirX, rayDirY, rayDirZ;
    logic                      frameDone;
    int                        errorCount;
    int                        threadCount;
    int                        seed;

    threadGenerator threadGenerator_inst (.*);
    threadGeneratorMonitor threadGeneratorMonitor_inst (.*);

    bind threadGenerator threadGenerator_chk threadGenerator_chk_inst (
        .clk         (clk),
        .resetn      (resetn),
        .fifoFull    (fifoFull),
        .threadValid (threadValid),
        .threadCore  (threadCore)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Signed value strictly inside +-range
    function automatic fixedT randomFixed(int range);
        return fixedT'($random(seed) % range);
    endfunction

    // Each core full about a quarter of the time
    function automatic logic [`RAY_CORE_SIZE-1:0] randomFull();
        logic [`RAY_CORE_SIZE-1:0] full;
        for (int i = 0; i < `RAY_CORE_SIZE; i++) begin
            full[i] = (($random(seed) & 3) == 0);
        end
        return full;
    endfunction

    task automatic loadCamera();
        camPosX <= randomFixed(8 << 16);
        camPosY <= randomFixed(8 << 16);
        camPosZ <= randomFixed(8 << 16);
        camBlcX <= randomFixed(8 << 16);
        camBlcY <= randomFixed(8 << 16);
        camBlcZ <= randomFixed(8 << 16);
        camRhX  <= randomFixed(1 << 16);
        camRhY  <= randomFixed(1 << 16);
        camRhZ  <= randomFixed(1 << 16);
        camRvX  <= randomFixed(1 << 16);
        camRvY  <= randomFixed(1 << 16);
        camRvZ  <= randomFixed(1 << 16);
        // Small pixel pitch
        camCub  <= randomFixed(4096);
        camCvb  <= randomFixed(4096);
        viewportHeight <= coordT'(`FRAMEBUFFER_HEIGHT + ($unsigned($random(seed)) % 8));
    endtask

    task automatic stepCycle();
        @(posedge clk);
        fifoFull <= randomFull();
    endtask

    // Restart, strobe, then run until the monitor sees the last pixel
    task automatic runFrame(input coordT startX, input coordT startY);
        @(posedge clk);
        loadCamera();
        x0       <= startX;
        y0       <= startY;
        restart  <= 1'b1;
        fifoFull <= randomFull();
        @(posedge clk);
        restart  <= 1'b0;
        fifoFull <= randomFull();
        repeat (3) stepCycle();
        @(posedge clk);
        strobe   <= 1'b1;
        fifoFull <= randomFull();
        @(posedge clk);
        strobe   <= 1'b0;
        fifoFull <= randomFull();
        while (!frameDone) begin
            stepCycle();
        end
        // Idle stretch, monitor flags any stray thread
        repeat (20) stepCycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, sequence, watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        coordT startX;
        coordT startY;
        int    assertFails;
        seed     = 25;
        resetn   = 1'b0;
        restart  = 1'b0;
        strobe   = 1'b0;
        x0       = '0;
        y0       = '0;
        fifoFull = '0;
        loadCamera();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        // Full frame from the corner
        runFrame('0, '0);
        // Partial frame from a random origin
        startX = coordT'($unsigned($random(seed)) % `FRAMEBUFFER_WIDTH);
        startY = coordT'($unsigned($random(seed)) % `FRAMEBUFFER_HEIGHT);
        runFrame(startX, startY);

        assertFails = threadGenerator_inst.threadGenerator_chk_inst.failCount;
        $display("Threads checked: %0d, mismatches: %0d, assertion failures: %0d",
                 threadCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: frames did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: sim/threadGeneratorMonitor.sv
`include "rtMacros_macros.svh"

module threadGeneratorMonitor
    import rtPkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    restart,
    input  logic    strobe,
    input  coordT   x0,
    input  coordT   y0,
    input  coordT   viewportHeight,
    input  fixedT   camPosX, camPosY, camPosZ,
    input  fixedT   camBlcX, camBlcY, camBlcZ,
    input  fixedT   camRhX, camRhY, camRhZ,
    input  fixedT   camRvX, camRvY, camRvZ,
    input  fixedT   camCub,
    input  fixedT   camCvb,
    input  logic    threadValid,
    input  coreIdxT threadCore,
    input  coordT   threadX,
    input  coordT   threadY,
    input  fixedT   rayDirX, rayDirY, rayDirZ,
    output logic    frameDone,
    output int      errorCount,
    output int      threadCount
);
    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////

    // Frame origin captured at restart
    int startX;
    int startY;
    // Next pixel and core expected
    int expX;
    int expY;
    int expCore;
    int frameThreads;
    // Strobe seen for the loaded frame
    logic running;

    // Q16.16 product: full width, arithmetic shift, low word kept
    function automatic fixedT mulQ16(fixedT a, fixedT b);
        logic signed [2*`FIXED_WIDTH-1:0] wideA;
        logic signed [2*`FIXED_WIDTH-1:0] wideB;
        logic signed [2*`FIXED_WIDTH-1:0] product;
        wideA = a;
        wideB = b;
        product = (wideA * wideB) >>> `FIXED_FRAC;
        return product[`FIXED_WIDTH-1:0];
    endfunction

    task automatic expectEqual(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Pixel, core and ray direction of one thread
    task automatic checkThread();
        fixedT xf;
        fixedT yf;
        fixedT cu;
        fixedT cv;
        coordT yRow;
        // Camera rows count upward from the bottom
        yRow = viewportHeight - coordT'(1) - coordT'(expY);
        xf = '0;
        xf[`FIXED_FRAC +: `SCREEN_COORD_WIDTH] = coordT'(expX);
        yf = '0;
        yf[`FIXED_FRAC +: `SCREEN_COORD_WIDTH] = yRow;
        cu = mulQ16(xf, camCub);
        cv = mulQ16(yf, camCvb);
        expectEqual("threadX", threadX, expX);
        expectEqual("threadY", threadY, expY);
        expectEqual("threadCore", threadCore, expCore);
        expectEqual("rayDirX", rayDirX,
                    mulQ16(cu, camRhX) + mulQ16(cv, camRvX) + camBlcX - camPosX);
        expectEqual("rayDirY", rayDirY,
                    mulQ16(cu, camRhY) + mulQ16(cv, camRvY) + camBlcY - camPosY);
        expectEqual("rayDirZ", rayDirZ,
                    mulQ16(cu, camRhZ) + mulQ16(cv, camRvZ) + camBlcZ - camPosZ);
    endtask

    // Raster step, row restarts at the origin column
    task automatic stepModel();
        int nx;
        int ny;
        int frameSize;
        nx = expX + 1;
        ny = expY;
        if (nx >= `FRAMEBUFFER_WIDTH) begin
            nx = startX;
            ny = expY + 1;
        end
        expX <= nx;
        expY <= ny;
        expCore <= (expCore + 1) % `RAY_CORE_SIZE;
        frameThreads <= frameThreads + 1;
        if (ny >= `FRAMEBUFFER_HEIGHT) begin
            frameDone <= 1'b1;
        end
        // Last pixel as the DUT reports it closes the count
        if (threadX == coordT'(`FRAMEBUFFER_WIDTH - 1) &&
            threadY == coordT'(`FRAMEBUFFER_HEIGHT - 1)) begin
            frameSize = (`FRAMEBUFFER_HEIGHT - startY) * (`FRAMEBUFFER_WIDTH - startX);
            expectEqual("frame thread count", frameThreads + 1, frameSize);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle comparison
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            frameDone    <= 1'b1;
            running      <= 1'b0;
            startX       <= 0;
            startY       <= 0;
            expX         <= 0;
            expY         <= 0;
            expCore      <= 0;
            frameThreads <= 0;
        end else begin
            // New frame only accepted while idle
            if (restart && frameDone) begin
                startX       <= x0;
                startY       <= y0;
                expX         <= x0;
                expY         <= y0;
                expCore      <= 0;
                frameThreads <= 0;
                frameDone    <= 1'b0;
                running      <= 1'b0;
            end
            // Scan starts on strobe once a frame is loaded
            if (strobe && !frameDone) begin
                running <= 1'b1;
            end
            if (threadValid) begin
                threadCount++;
                if (frameDone || !running) begin
                    errorCount++;
                    $display("Thread seen at %0t while no frame was running", $time);
                end else begin
                    checkThread();
                    stepModel();
                end
            end
        end
    end

endmodule

// File: sim/threadGenerator_chk.sv
`include "rtMacros_macros.svh"

module threadGenerator_chk
    import rtPkg::*;
(
    input logic                      clk,
    input logic                      resetn,
    input logic [`RAY_CORE_SIZE-1:0] fifoFull,
    input logic                      threadValid,
    input coreIdxT                   threadCore
);
    timeunit 1ns;
    timeprecision 100ps;

    // Running total of failed properties
    int failCount;

    ////////////////////////////////////////////////////////////
    // Port properties
    ////////////////////////////////////////////////////////////

    // Core must have had room on the issue cycle, two edges back
    backPressure: assert property (@(posedge clk) disable iff (!resetn)
        threadValid |-> ((($past(fifoFull, 2) >> threadCore) & 1) == 0))
        else begin
            $error("thread sent to core %0d while its FIFO was full", threadCore);
            failCount++;
        end

    // Issue rate is at most one every other cycle
    validSpacing: assert property (@(posedge clk) disable iff (!resetn)
        threadValid |=> !threadValid)
        else begin
            $error("threadValid high on two cycles in a row");
            failCount++;
        end

    // Nothing leaves the pipeline in the first cycles after reset release
    idleAfterReset: assert property (@(posedge clk)
        (resetn && !$past(resetn, 4)) |-> !threadValid)
        else begin
            $error("threadValid high right after reset");
            failCount++;
        end

endmodule

// File: src/threadGenerator.sv
`include "rtMacros_macros.svh"

module threadGenerator
    import rtPkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      restart,
    input  logic                      strobe,
    input  coordT                     x0,
    input  coordT                     y0,
    input  logic [`RAY_CORE_SIZE-1:0] fifoFull,
    input  fixedT                     camPosX,
    input  fixedT                     camPosY,
    input  fixedT                     camPosZ,
    input  fixedT                     camBlcX,
    input  fixedT                     camBlcY,
    input  fixedT                     camBlcZ,
    input  fixedT                     camRhX,
    input  fixedT                     camRhY,
    input  fixedT                     camRhZ,
    input  fixedT                     camRvX,
    input  fixedT                     camRvY,
    input  fixedT                     camRvZ,
    input  fixedT                     camCub,
    input  fixedT                     camCvb,
    input  coordT                     viewportHeight,
    output logic                      threadValid,
    output coreIdxT                   threadCore,
    output coordT                     threadX,
    output coordT                     threadY,
    output fixedT                     rayDirX,
    output fixedT                     rayDirY,
    output fixedT                     rayDirZ
);

    ////////////////////////////////////////////////////////////
    // Scanner to direction pipeline
    ////////////////////////////////////////////////////////////

    logic    issue;
    coreIdxT issueCore;
    coordT   issueX;
    coordT   issueY;

    // Frame walk, core rotation, back-pressure
    pixelScanner pixelScanner_inst (
        .clk       (clk),
        .resetn    (resetn),
        .restart   (restart),
        .strobe    (strobe),
        .x0        (x0),
        .y0        (y0),
        .fifoFull  (fifoFull),
        .issue     (issue),
        .issueCore (issueCore),
        .issueX    (issueX),
        .issueY    (issueY)
    );

    // Two-cycle camera ray pipeline
    rayDirection rayDirection_inst (
        .clk            (clk),
        .resetn         (resetn),
        .issue          (issue),
        .issueCore      (issueCore),
        .issueX         (issueX),
        .issueY         (issueY),
        .viewportHeight (viewportHeight),
        .camPosX        (camPosX),
        .camPosY        (camPosY),
        .camPosZ        (camPosZ),
        .camBlcX        (camBlcX),
        .camBlcY        (camBlcY),
        .camBlcZ        (camBlcZ),
        .camRhX         (camRhX),
        .camRhY         (camRhY),
        .camRhZ         (camRhZ),
        .camRvX         (camRvX),
        .camRvY         (camRvY),
        .camRvZ         (camRvZ),
        .camCub         (camCub),
        .camCvb         (camCvb),
        .threadValid    (threadValid),
        .threadCore     (threadCore),
        .threadX        (threadX),
        .threadY        (threadY),
        .rayDirX        (rayDirX),
        .rayDirY        (rayDirY),
        .rayDirZ        (rayDirZ)
    );

endmodule

// File: src/rayDirection.sv
`include "rtMacros_macros.svh"

module rayDirection
    import rtPkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    issue,
    input  coreIdxT issueCore,
    input  coordT   issueX,
    input  coordT   issueY,
    input  coordT   viewportHeight,
    input  fixedT   camPosX,
    input  fixedT   camPosY,
    input  fixedT   camPosZ,
    input  fixedT   camBlcX,
    input  fixedT   camBlcY,
    input  fixedT   camBlcZ,
    input  fixedT   camRhX,
    input  fixedT   camRhY,
    input  fixedT   camRhZ,
    input  fixedT   camRvX,
    input  fixedT   camRvY,
    input  fixedT   camRvZ,
    input  fixedT   camCub,
    input  fixedT   camCvb,
    output logic    threadValid,
    output coreIdxT threadCore,
    output coordT   threadX,
    output coordT   threadY,
    output fixedT   rayDirX,
    output fixedT   rayDirY,
    output fixedT   rayDirZ
);

    // Integer pixel coordinate to Q16.16
    function automatic fixedT coordToFixed(coordT c);
        return fixedT'(c) << `FIXED_FRAC;
    endfunction

    // One direction component: CU*rh + CV*rv + blc - pos
    function automatic fixedT dirComponent(fixedT cu, fixedT cv, fixedT rh,
                                           fixedT rv, fixedT blc, fixedT pos);
        return fixedMul(cu, rh) + fixedMul(cv, rv) + blc - pos;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stage one: scalar products
    ////////////////////////////////////////////////////////////

    // Screen y runs bottom-up in camera space
    coordT yFlip;
    assign yFlip = viewportHeight - coordT'(1) - issueY;

    logic    s1Valid;
    coreIdxT s1Core;
    coordT   s1X;
    coordT   s1Y;
    fixedT   s1Cu;
    fixedT   s1Cv;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue;
        end
    end

    // Payload held between threads
    always_ff @(posedge clk) begin
        if (issue) begin
            s1Core <= issueCore;
            s1X    <= issueX;
            s1Y    <= issueY;
            s1Cu   <= fixedMul(coordToFixed(issueX), camCub);
            s1Cv   <= fixedMul(coordToFixed(yFlip), camCvb);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two: vector multiplies and sums
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            threadValid <= 1'b0;
            threadCore  <= '0;
            threadX     <= '0;
            threadY     <= '0;
            rayDirX     <= '0;
            rayDirY     <= '0;
            rayDirZ     <= '0;
        end else begin
            threadValid <= s1Valid;
            if (s1Valid) begin
                threadCore <= s1Core;
                threadX    <= s1X;
                threadY    <= s1Y;
                rayDirX    <= dirComponent(s1Cu, s1Cv, camRhX, camRvX, camBlcX, camPosX);
                rayDirY    <= dirComponent(s1Cu, s1Cv, camRhY, camRvY, camBlcY, camPosY);
                rayDirZ    <= dirComponent(s1Cu, s1Cv, camRhZ, camRvZ, camBlcZ, camPosZ);
            end
        end
    end

endmodule

// File: src/pixelScanner.sv
`include "rtMacros_macros.svh"

module pixelScanner
    import rtPkg::*;
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      restart,
    input  logic                      strobe,
    input  coordT                     x0,
    input  coordT                     y0,
    input  logic [`RAY_CORE_SIZE-1:0] fifoFull,
    output logic                      issue,
    output coreIdxT                   issueCore,
    output coordT                     issueX,
    output coordT                     issueY
);

    ////////////////////////////////////////////////////////////
    // Scan state
    ////////////////////////////////////////////////////////////

    threadGenStateT state;

    // Pixel about to be issued
    coordT curX;
    coordT curY;

    // Round-robin pointer
    coreIdxT corePtr;

    // Back-pressure from the core being served
    logic curCoreFull;

    // Step values for NextThread
    coordT   nextX;
    coordT   nextY;
    coreIdxT nextCore;
    logic    rowEnd;
    logic    frameEnd;

    ////////////////////////////////////////////////////////////
    // Combinational decode
    ////////////////////////////////////////////////////////////

    assign curCoreFull = fifoFull[corePtr];

    // One thread per Generate visit, only when the core has room
    assign issue = (state == tgsGenerate) && !curCoreFull;

    assign issueCore = corePtr;
    assign issueX    = curX;
    assign issueY    = curY;

    assign nextX = curX + coordT'(1);
    assign nextY = curY + coordT'(1);

    // Wrap modulo core count
    assign nextCore = (corePtr == coreIdxT'(`RAY_CORE_SIZE - 1)) ?
                      '0 : corePtr + coreIdxT'(1);

    // Right edge reached, row restarts at x0
    assign rowEnd = (nextX >= coordT'(`FRAMEBUFFER_WIDTH));

    // Bottom row finished
    assign frameEnd = rowEnd && (nextY >= coordT'(`FRAMEBUFFER_HEIGHT));

    ////////////////////////////////////////////////////////////
    // FSM and pixel walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= tgsInit;
            curX    <= '0;
            curY    <= '0;
            corePtr <= '0;
        end else begin
            case (state)
                tgsInit: begin
                    // Only place a new frame can start
                    if (restart) begin
                        curX    <= x0;
                        curY    <= y0;
                        corePtr <= '0;
                        state   <= tgsWait;
                    end
                end

                tgsWait: begin
                    if (strobe) begin
                        state <= tgsGenerate;
                    end
                end

                tgsGenerate: begin
                    // Full core is retried, never skipped
                    if (!curCoreFull) begin
                        state <= tgsNextThread;
                    end
                end

                tgsNextThread: begin
                    corePtr <= nextCore;
                    if (rowEnd) begin
                        curX <= x0;
                        curY <= nextY;
                    end else begin
                        curX <= nextX;
                    end
                    // Frame done, back to idle
                    state <= frameEnd ? tgsInit : tgsGenerate;
                end

                default: begin
                    state <= tgsInit;
                end
            endcase
        end
    end

endmodule

// File: src/rtPkg.sv
`include "rtMacros_macros.svh"

package rtPkg;

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    // Signed Q16.16 word
    typedef logic signed [`FIXED_WIDTH-1:0] fixedT;

    // Pixel coordinate, unsigned
    typedef logic [`SCREEN_COORD_WIDTH-1:0] coordT;

    // Index of a ray core
    typedef logic [`RAY_CORE_SIZE_WIDTH-1:0] coreIdxT;

    // Thread generator FSM states
    typedef enum logic [1:0] {
        tgsInit,
        tgsWait,
        tgsGenerate,
        tgsNextThread
    } threadGenStateT;

    ////////////////////////////////////////////////////////////
    // Fixed-point helpers
    ////////////////////////////////////////////////////////////

    // Full signed product, rescaled back to Q16.16
    function automatic fixedT fixedMul(fixedT a, fixedT b);
        logic signed [2*`FIXED_WIDTH-1:0] prod;
        logic signed [2*`FIXED_WIDTH-1:0] scaled;
        // Both operands signed, so they sign-extend to the product width
        prod = a * b;
        scaled = prod >>> `FIXED_FRAC;
        // Upper bits dropped, wraps like the adders
        return scaled[`FIXED_WIDTH-1:0];
    endfunction

endpackage

// File: include/rtMacros_macros.svh
`ifndef RT_MACROS_SVH
`define RT_MACROS_SVH

////////////////////////////////////////////////////////////
// Fixed-point format
////////////////////////////////////////////////////////////

// Q16.16 word
`define FIXED_WIDTH 32
`define FIXED_FRAC 16

////////////////////////////////////////////////////////////
// Screen and core layout
////////////////////////////////////////////////////////////

`define SCREEN_COORD_WIDTH 10
// Ray cores fed round-robin
`define RAY_CORE_SIZE 4
`define RAY_CORE_SIZE_WIDTH 2
// Frame size in pixels
`define FRAMEBUFFER_WIDTH 40
`define FRAMEBUFFER_HEIGHT 30

`endif
